/* common/gba_fe_pkg.sv */
// gba_fe_pkg holds the loader and video types and constants shared by the front end
`default_nettype none

package gba_fe_pkg;

	// ========================================
	// loader side

	typedef enum logic [1:0] {
		IDLE,
		CART_LOAD,
		BIOS_LOAD
	} load_state_t;

	typedef struct packed {
		logic        download;   // level for the whole transfer
		logic [7:0]  index;      // image kind
		logic        wr;         // one strobe per halfword
		logic [26:0] addr;       // byte address
		logic [15:0] data;       // lower byte address in bits 7:0
	} ioctl_t;

	typedef struct packed {
		logic        valid;
		logic [24:0] addr;       // word address
		logic [31:0] data;
	} mem_wr_t;

	typedef struct packed {
		logic no_sram;
		logic remap;
		logic gpio;
		logic tilt;
		logic solar;
		logic sprite_limit;
		logic flash_1m;
	} quirk_t;

	localparam logic [5:0] IDX_CART     = 6'd1;
	localparam logic [5:0] IDX_BIOS     = 6'd0;   // needs index bits 7:6 clear
	localparam logic [5:0] IDX_BIOS_ALT = 6'd2;

	localparam logic [26:0] HDR_CODE_ADDR = 27'h0AC;   // first game code character
	localparam logic [26:0] HDR_DONE_ADDR = 27'h0B0;   // lookup runs on this write

	// ========================================
	// video side

	typedef struct packed {
		logic [5:0] r;
		logic [5:0] g;
		logic [5:0] b;
	} rgb_t;

	typedef struct packed {
		logic hs;
		logic vs;
		logic hbl;
		logic vbl;
		logic pix_ce;
	} vid_sync_t;

	localparam int H_ACTIVE      = 240;
	localparam int V_ACTIVE      = 160;
	localparam int H_TOTAL       = 399;
	localparam int V_TOTAL       = 264;
	localparam int HS_START      = 293;
	localparam int HS_WIDTH      = 32;
	localparam int VS_START_LINE = 1;
	localparam int VS_END_LINE   = 4;
	localparam int V_START       = 62;    // first visible line
	localparam int FB_WORDS      = 38400;
	localparam int FB_ADDR_W     = 16;

endpackage

`default_nettype wire

/* loader/load_fsm.sv */
// load_fsm tracks the cartridge and BIOS download state and keeps the last cart address
`timescale 1ns/1ps
`default_nettype none

module load_fsm (
	input  wire                         clk_sys,
	input  wire                         reset,
	input  wire gba_fe_pkg::ioctl_t     ioctl,
	output gba_fe_pkg::load_state_t     state,
	output logic                        cart_start,
	output logic                        cart_active,
	output logic [26:0]                 last_addr
);

	logic cart_req;                          // index asks for a cartridge image
	logic bios_req;                          // index asks for a BIOS image
	logic [26:0] wr_addr_q;                  // address of the latest cart write
	gba_fe_pkg::load_state_t state_next;

	assign cart_req = ioctl.index[5:0] == gba_fe_pkg::IDX_CART;
	assign bios_req = (ioctl.index == {2'b00, gba_fe_pkg::IDX_BIOS}) ||
		(ioctl.index[5:0] == gba_fe_pkg::IDX_BIOS_ALT);

	assign cart_active = state == gba_fe_pkg::CART_LOAD;

	always_comb begin
		state_next = state;
		case (state)
			gba_fe_pkg::IDLE: begin
				if (ioctl.download && cart_req)
					state_next = gba_fe_pkg::CART_LOAD;
				else if (ioctl.download && bios_req)
					state_next = gba_fe_pkg::BIOS_LOAD;
			end
			gba_fe_pkg::CART_LOAD,
			gba_fe_pkg::BIOS_LOAD: begin
				if (!ioctl.download)
					state_next = gba_fe_pkg::IDLE;   // back to idle once the level drops
			end
			default: state_next = gba_fe_pkg::IDLE;
		endcase
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state      <= gba_fe_pkg::IDLE;
			cart_start <= 1'b0;
			wr_addr_q  <= '0;
			last_addr  <= '0;
		end else begin
			state      <= state_next;
			// one pulse in the first CART_LOAD cycle
			cart_start <= (state == gba_fe_pkg::IDLE) && (state_next == gba_fe_pkg::CART_LOAD);
			if (cart_active && ioctl.wr)
				wr_addr_q <= ioctl.addr;
			if (cart_active && !ioctl.download)
				last_addr <= wr_addr_q;              // end of the cart image
		end
	end

endmodule

`default_nettype wire

/* loader/word_packer.sv */
// word_packer joins loader halfwords into 32-bit ROM and BIOS word writes
`timescale 1ns/1ps
`default_nettype none

module word_packer #(
	parameter int ROM_BASE_WORD = 196608
) (
	input  wire                          clk_sys,
	input  wire                          reset,
	input  wire gba_fe_pkg::ioctl_t      ioctl,
	input  wire gba_fe_pkg::load_state_t state,
	output gba_fe_pkg::mem_wr_t          rom_wr,
	output gba_fe_pkg::mem_wr_t          bios_wr
);

	localparam logic [24:0] ROM_BASE = 25'(ROM_BASE_WORD);

	logic        hi_wr;           // odd halfword closes a word
	logic [15:0] low_half;
	logic [31:0] word_q;
	logic [24:0] rom_addr_q;
	logic [24:0] bios_addr_q;
	logic        rom_valid;
	logic        bios_valid;

	assign hi_wr = ioctl.wr & ioctl.addr[1];

	// payload registers
	always_ff @(posedge clk_sys) begin
		if (ioctl.wr && !ioctl.addr[1])
			low_half <= ioctl.data;
		if (hi_wr) begin
			word_q      <= {ioctl.data, low_half};
			rom_addr_q  <= ROM_BASE + ioctl.addr[26:2];
			bios_addr_q <= {13'd0, ioctl.addr[13:2]};   // 4 KB word BIOS space
		end
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			rom_valid  <= 1'b0;
			bios_valid <= 1'b0;
		end else begin
			rom_valid  <= hi_wr && (state == gba_fe_pkg::CART_LOAD);
			bios_valid <= hi_wr && (state == gba_fe_pkg::BIOS_LOAD);
		end
	end

	assign rom_wr  = '{valid: rom_valid, addr: rom_addr_q, data: word_q};
	assign bios_wr = '{valid: bios_valid, addr: bios_addr_q, data: word_q};

endmodule

`default_nettype wire

/* loader/header_scan.sv */
// header_scan reads the cart game code, applies the quirk table and spots the 1M flash tag
`timescale 1ns/1ps
`default_nettype none

module header_scan (
	input  wire                     clk_sys,
	input  wire                     reset,
	input  wire gba_fe_pkg::ioctl_t ioctl,
	input  wire                     cart_start,
	input  wire                     cart_active,
	output gba_fe_pkg::quirk_t      quirks
);

	localparam logic [71:0] FLASH_TAG    = "FLASH1M_V";
	localparam logic [26:0] CODE_HI_ADDR = gba_fe_pkg::HDR_CODE_ADDR;
	localparam logic [26:0] CODE_LO_ADDR = gba_fe_pkg::HDR_CODE_ADDR + 27'd2;

	logic               scan_wr;      // cart write seen by the scanner
	logic [7:0]         lo_byte;      // lower byte address
	logic [7:0]         hi_byte;
	logic [31:0]        game_code;    // first character in bits 31:24
	logic [63:0]        window;       // last eight bytes, newest lowest
	logic               flash_hit;
	gba_fe_pkg::quirk_t table_hit;

	assign scan_wr = cart_active & ioctl.wr;
	assign lo_byte = ioctl.data[7:0];
	assign hi_byte = ioctl.data[15:8];

	// the tag may end on either byte of this halfword
	assign flash_hit = ({window, lo_byte} == FLASH_TAG) ||
		({window[55:0], lo_byte, hi_byte} == FLASH_TAG);

	// ========================================
	// compatibility table

	always_comb begin
		table_hit = '0;
		case (game_code[31:8])           // three character entries
			"AR8": table_hit.no_sram = 1'b1;
			"BPE": table_hit.gpio = 1'b1;
			"BHG": table_hit.sprite_limit = 1'b1;
			"KYG": table_hit.tilt = 1'b1;
			"U3I": begin
				table_hit.gpio  = 1'b1;
				table_hit.solar = 1'b1;  // solar sensor sits on the gpio port
			end
			default: ;
		endcase
		case (game_code)                 // full four character entries
			"FSMJ": begin
				table_hit.no_sram = 1'b1;
				table_hit.remap   = 1'b1;
			end
			"FSDJ": begin
				table_hit.no_sram      = 1'b1;
				table_hit.remap        = 1'b1;
				table_hit.sprite_limit = 1'b1;
			end
			default: ;
		endcase
	end

	// ========================================
	// header capture

	always_ff @(posedge clk_sys) begin
		if (scan_wr && ioctl.addr == CODE_HI_ADDR)
			game_code[31:16] <= {lo_byte, hi_byte};
		if (scan_wr && ioctl.addr == CODE_LO_ADDR)
			game_code[15:0] <= {lo_byte, hi_byte};
	end

	always_ff @(posedge clk_sys) begin
		if (cart_start)
			window <= '0;
		else if (scan_wr)
			window <= {window[47:0], lo_byte, hi_byte};
	end

	always_ff @(posedge clk_sys) begin
		if (reset || cart_start) begin
			quirks <= '0;
		end else if (scan_wr) begin
			if (ioctl.addr == gba_fe_pkg::HDR_DONE_ADDR)
				quirks <= quirks | table_hit;   // flags only accumulate within a load
			if (flash_hit)
				quirks.flash_1m <= 1'b1;
		end
	end

endmodule

`default_nettype wire

/* video/video_timing.sv */
// video_timing divides the clock to the pixel rate and makes beam counters, sync, blank and read address
`timescale 1ns/1ps
`default_nettype none

module video_timing #(
	parameter int PIX_DIV = 8
) (
	input  wire                                clk_sys,
	input  wire                                reset,
	output gba_fe_pkg::vid_sync_t              sync,
	output logic [gba_fe_pkg::FB_ADDR_W-1:0]   rd_addr
);

	localparam int DIV_W = (PIX_DIV > 1) ? $clog2(PIX_DIV) : 1;
	localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(PIX_DIV - 1);

	localparam logic [8:0] X_ACT  = 9'(gba_fe_pkg::H_ACTIVE);
	localparam logic [8:0] X_LAST = 9'(gba_fe_pkg::H_TOTAL - 1);
	localparam logic [8:0] Y_LAST = 9'(gba_fe_pkg::V_TOTAL - 1);
	localparam logic [8:0] HS_ON  = 9'(gba_fe_pkg::HS_START);
	localparam logic [8:0] HS_OFF = 9'(gba_fe_pkg::HS_START + gba_fe_pkg::HS_WIDTH);
	localparam logic [8:0] VS_ON  = 9'(gba_fe_pkg::VS_START_LINE);
	localparam logic [8:0] VS_OFF = 9'(gba_fe_pkg::VS_END_LINE);
	localparam logic [8:0] Y_ACT0 = 9'(gba_fe_pkg::V_START);
	localparam logic [8:0] Y_ACT1 = 9'(gba_fe_pkg::V_START + gba_fe_pkg::V_ACTIVE);

	logic [DIV_W-1:0] div;
	logic [8:0]       x;
	logic [8:0]       y;
	logic             tick;       // last clock before a pixel strobe
	logic             h_act;
	logic             v_act;
	logic             hs_edge;    // x at the hsync start column

	assign tick    = div == DIV_LAST;
	assign h_act   = x < X_ACT;
	assign v_act   = (y >= Y_ACT0) && (y < Y_ACT1);
	assign hs_edge = x == HS_ON;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			div     <= '0;
			x       <= '0;
			y       <= '0;
			rd_addr <= '0;
			sync    <= '{hs: 1'b0, vs: 1'b0, hbl: 1'b1, vbl: 1'b1, pix_ce: 1'b0};
		end else begin
			div         <= tick ? '0 : div + 1'b1;
			sync.pix_ce <= tick;

			// everything below shows up together with pix_ce
			if (tick) begin
				sync.hbl <= !h_act;
				sync.vbl <= !v_act;
				sync.hs  <= (x >= HS_ON) && (x < HS_OFF);
				if (hs_edge && y == VS_ON)
					sync.vs <= 1'b1;
				if (hs_edge && y == VS_OFF)
					sync.vs <= 1'b0;

				// counts the pixels shown so far, so it names the next one
				if (!v_act)
					rd_addr <= '0;
				else if (h_act)
					rd_addr <= rd_addr + 1'b1;

				if (x == X_LAST) begin
					x <= '0;
					y <= (y == Y_LAST) ? '0 : y + 1'b1;   // free running, no realignment
				end else begin
					x <= x + 1'b1;
				end
			end
		end
	end

endmodule

`default_nettype wire

/* video/frame_buffer.sv */
// frame_buffer stores one 240x160 frame and presents the current pixel on each strobe
`timescale 1ns/1ps
`default_nettype none

module frame_buffer (
	input  wire                                clk_sys,
	input  wire                                we,
	input  wire [gba_fe_pkg::FB_ADDR_W-1:0]    wr_addr,
	input  wire gba_fe_pkg::rgb_t              wr_data,
	input  wire [gba_fe_pkg::FB_ADDR_W-1:0]    rd_addr,
	input  wire                                pix_ce,
	output gba_fe_pkg::rgb_t                   rgb
);

	localparam logic [gba_fe_pkg::FB_ADDR_W-1:0] DEPTH =
		gba_fe_pkg::FB_ADDR_W'(gba_fe_pkg::FB_WORDS);

	gba_fe_pkg::rgb_t mem [gba_fe_pkg::FB_WORDS];

	logic wr_ok;                 // drop writes past the last entry

	assign wr_ok = we && (wr_addr < DEPTH);

	// ========================================
	// core side write port

	always_ff @(posedge clk_sys) begin
		if (wr_ok)
			mem[wr_addr] <= wr_data;
	end

	// ========================================
	// display side read port
	// rd_addr already counts the strobe in progress, so the word read now
	// is the one due at the next strobe

	always_ff @(posedge clk_sys) begin
		if (pix_ce)
			rgb <= mem[rd_addr];
	end

endmodule

`default_nettype wire

/* logic/gba_fe_top.sv */
// gba_fe_top joins the download path and the video output stage of the handheld front end
`timescale 1ns/1ps
`default_nettype none

module gba_fe_top #(
	parameter int PIX_DIV       = 8,
	parameter int ROM_BASE_WORD = 196608
) (
	input  wire                                clk_sys,
	input  wire                                reset,
	input  wire gba_fe_pkg::ioctl_t            ioctl,
	input  wire                                pixel_we,
	input  wire [gba_fe_pkg::FB_ADDR_W-1:0]    pixel_addr,
	input  wire gba_fe_pkg::rgb_t              pixel_data,
	output gba_fe_pkg::mem_wr_t                rom_wr,
	output gba_fe_pkg::mem_wr_t                bios_wr,
	output gba_fe_pkg::quirk_t                 quirks,
	output logic [26:0]                        last_addr,
	output gba_fe_pkg::vid_sync_t              sync,
	output gba_fe_pkg::rgb_t                   rgb
);

	gba_fe_pkg::load_state_t               load_state;
	logic                                  cart_start;
	logic                                  cart_active;
	logic [gba_fe_pkg::FB_ADDR_W-1:0]      rd_addr;

	// ========================================
	// download path

	load_fsm u_load_fsm (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.ioctl       (ioctl),
		.state       (load_state),
		.cart_start  (cart_start),
		.cart_active (cart_active),
		.last_addr   (last_addr)
	);

	word_packer #(
		.ROM_BASE_WORD (ROM_BASE_WORD)
	) u_word_packer (
		.clk_sys (clk_sys),
		.reset   (reset),
		.ioctl   (ioctl),
		.state   (load_state),
		.rom_wr  (rom_wr),
		.bios_wr (bios_wr)
	);

	header_scan u_header_scan (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.ioctl       (ioctl),
		.cart_start  (cart_start),
		.cart_active (cart_active),
		.quirks      (quirks)
	);

	// ========================================
	// video output

	video_timing #(
		.PIX_DIV (PIX_DIV)
	) u_video_timing (
		.clk_sys (clk_sys),
		.reset   (reset),
		.sync    (sync),
		.rd_addr (rd_addr)
	);

	frame_buffer u_frame_buffer (
		.clk_sys (clk_sys),
		.we      (pixel_we),
		.wr_addr (pixel_addr),
		.wr_data (pixel_data),
		.rd_addr (rd_addr),
		.pix_ce  (sync.pix_ce),
		.rgb     (rgb)
	);

endmodule

`default_nettype wire

/* tb/gba_fe_checker.sv */
// gba_fe_checker watches the front end ports for write collisions, sync order and stable quirks
`timescale 1ns/1ps
`default_nettype none

module gba_fe_checker (
	input wire                        clk_sys,
	input wire                        reset,
	input wire gba_fe_pkg::ioctl_t    ioctl,
	input wire gba_fe_pkg::mem_wr_t   rom_wr,
	input wire gba_fe_pkg::mem_wr_t   bios_wr,
	input wire gba_fe_pkg::quirk_t    quirks,
	input wire gba_fe_pkg::vid_sync_t sync
);

	int unsigned fail_count = 0;   // failed assertions so far

	a_one_target: assert property (@(posedge clk_sys) disable iff (reset)
		!(rom_wr.valid && bios_wr.valid))
		else begin
			fail_count++;
			$error("rom and bios writes valid in the same cycle");
		end

	a_vs_in_vbl: assert property (@(posedge clk_sys) disable iff (reset)
		sync.vs |-> sync.vbl)
		else begin
			fail_count++;
			$error("vs high outside vertical blank");
		end

	// flags may move during a download and in the cycle after it ends
	a_quirks_stable: assert property (@(posedge clk_sys) disable iff (reset)
		$changed(quirks) |-> (ioctl.download || $past(ioctl.download)))
		else begin
			fail_count++;
			$error("quirk flags changed outside a download");
		end

endmodule

bind gba_fe_top gba_fe_checker u_checker (
	.clk_sys (clk_sys),
	.reset   (reset),
	.ioctl   (ioctl),
	.rom_wr  (rom_wr),
	.bios_wr (bios_wr),
	.quirks  (quirks),
	.sync    (sync)
);

`default_nettype wire

/* tb/gba_fe_tests.svh */
// gba_fe_tests holds the directed loader and video tests, each one driving the DUT and checking it
`ifndef GBA_FE_TESTS_SVH
`define GBA_FE_TESTS_SVH

// ========================================
// loader

task automatic clear_image;
	for (int i = 0; i < 512; i++)
		img[i] = 8'h00;
endtask

// one halfword per cycle, lower byte from the even address
task automatic send_image(input logic [7:0] index, input logic [26:0] base, input int nbytes);
	ioctl.download = 1'b1;
	ioctl.index    = index;
	repeat (3) next_cycle();   // state settles before the first write
	for (int a = 0; a < nbytes; a += 2) begin
		ioctl.wr   = 1'b1;
		ioctl.addr = base + 27'(a);
		ioctl.data = {img[a + 1], img[a]};
		next_cycle();
	end
	ioctl.wr       = 1'b0;
	ioctl.download = 1'b0;
	repeat (3) next_cycle();
endtask

task automatic test_reset_state;
	expect_eq("reset rom_wr valid", 0, rom_wr.valid);
	expect_eq("reset bios_wr valid", 0, bios_wr.valid);
	expect_eq("reset quirks", 0, quirks);
	expect_eq("reset last_addr", 0, last_addr);
	expect_eq("reset pix_ce", 0, sync.pix_ce);
	expect_eq("reset hs vs", 0, {sync.hs, sync.vs});
	expect_eq("reset hbl vbl", 2'b11, {sync.hbl, sync.vbl});
	expect_eq("reset x y", 0, {DUT.u_video_timing.x, DUT.u_video_timing.y});
	expect_eq("reset state", gba_fe_pkg::IDLE, DUT.u_load_fsm.state);
endtask

task automatic test_rom_load;
	logic [15:0] hw [64];
	clear_image();
	for (int i = 0; i < 64; i++) begin
		hw[i]          = 16'(take_bits(16));
		img[2 * i]     = hw[i][7:0];
		img[2 * i + 1] = hw[i][15:8];
	end
	rom_seen.delete();
	bios_seen.delete();
	send_image(8'h01, 27'd0, 128);
	expect_eq("rom load pulse count", 32, rom_seen.size());
	expect_eq("rom load bios pulses", 0, bios_seen.size());
	for (int i = 0; i < 32 && i < rom_seen.size(); i++) begin
		expect_eq("rom load address", ROM_BASE_WORD + i, rom_seen[i].addr);
		expect_eq("rom load data", {hw[2 * i + 1], hw[2 * i]}, rom_seen[i].data);
	end
	expect_eq("rom load last_addr", 126, last_addr);   // final halfword address
endtask

task automatic test_bios_load;
	logic [26:0] base;
	logic [26:0] a;
	base = 27'h0013ff0;   // word address wraps inside the 12-bit space
	clear_image();
	for (int i = 0; i < 32; i++)
		img[i] = 8'(take_bits(8));
	rom_seen.delete();
	bios_seen.delete();
	send_image(8'h02, base, 32);
	expect_eq("bios load pulse count", 8, bios_seen.size());
	expect_eq("bios load rom pulses", 0, rom_seen.size());
	for (int i = 0; i < 8 && i < bios_seen.size(); i++) begin
		a = base + 27'(4 * i);
		expect_eq("bios load address", {13'd0, a[13:2]}, bios_seen[i].addr);
		expect_eq("bios load data", {img[4 * i + 3], img[4 * i + 2], img[4 * i + 1], img[4 * i]},
			bios_seen[i].data);
	end
	expect_eq("bios load last_addr kept", 126, last_addr);
endtask

// ========================================
// header

task automatic load_header(input logic [31:0] code, input gba_fe_pkg::quirk_t exp,
		input string name);
	clear_image();
	img[9'h0ac] = code[31:24];   // first character is the most significant
	img[9'h0ad] = code[23:16];
	img[9'h0ae] = code[15:8];
	img[9'h0af] = code[7:0];
	send_image(8'h01, 27'd0, 9'h0c0);
	expect_eq(name, exp, quirks);
endtask

task automatic load_flash_tag(input int offset, input string name);
	logic [71:0]        tag;
	gba_fe_pkg::quirk_t exp;
	tag = "FLASH1M_V";
	exp = '0;
	exp.flash_1m = 1'b1;
	clear_image();
	for (int i = 0; i < 9; i++)
		img[offset + i] = tag[71 - 8 * i -: 8];
	send_image(8'h01, 27'd0, 9'h110);
	expect_eq(name, exp, quirks);
endtask

task automatic test_header_lookup;
	gba_fe_pkg::quirk_t exp;
	exp = '0;
	exp.gpio = 1'b1;
	load_header("BPEJ", exp, "header BPE");
	exp.solar = 1'b1;
	load_header("U3IP", exp, "header U3I");
	exp = '0;
	exp.no_sram      = 1'b1;
	exp.remap        = 1'b1;
	exp.sprite_limit = 1'b1;
	load_header("FSDJ", exp, "header FSDJ");
	load_header("ZZZZ", '0, "header flags cleared");
	load_flash_tag(9'h101, "flash tag odd offset");
	load_flash_tag(9'h100, "flash tag even offset");
endtask

// ========================================
// video

task automatic test_frame_readback;
	gba_fe_pkg::vid_sync_t s;
	logic vs_q;
	logic hs_q;
	logic started;
	logic done;
	int   k;
	int   lines;
	int   act_lines;
	int   line_act;
	int   hs_run;
	int   vs_strobes;
	for (int i = 0; i < 38400; i++) begin
		fb_ref[i]  = 18'(take_bits(18));
		pixel_we   = 1'b1;
		pixel_addr = 16'(i);
		pixel_data = fb_ref[i];
		next_cycle();
	end
	pixel_we = 1'b0;

	vs_q       = 1'b1;   // wait for a real rising edge
	hs_q       = 1'b1;
	started    = 1'b0;
	done       = 1'b0;
	k          = 0;
	lines      = 0;
	act_lines  = 0;
	line_act   = 0;
	hs_run     = 0;
	vs_strobes = 0;
	// one frame runs from one vs rise to the next
	while (!done) begin
		@(negedge clk_sys);
		if (sync.pix_ce) begin
			s = sync;
			if (s.vs && !vs_q) begin
				done    = started;
				started = 1'b1;
			end
			if (started && !done) begin
				if (s.hs && !hs_q) begin   // hs rise opens the next line
					if (line_act != 0) begin
						expect_eq("frame pixels per line", 240, line_act);
						act_lines++;
					end
					line_act = 0;
					hs_run   = 0;
					lines++;
				end
				if (!s.hs && hs_q)
					expect_eq("frame hs width", 32, hs_run);
				if (s.hs)
					hs_run++;
				if (s.vs)
					vs_strobes++;
				if (!s.hbl && !s.vbl) begin
					if (k < 38400)
						expect_eq("frame pixel", fb_ref[k], rgb);
					k++;
					line_act++;
				end
			end
			vs_q = s.vs;
			hs_q = s.hs;
		end
	end
	expect_eq("frame active pixels", 38400, k);
	expect_eq("frame active lines", 160, act_lines);
	expect_eq("frame lines", 264, lines);
	expect_eq("frame vs strobes", 3 * 399, vs_strobes);   // three full lines
endtask

`endif

/* tb/gba_fe_tb.sv */
// gba_fe_tb runs the directed loader and video tests against the front end and reports the result
`timescale 1ns/1ps
`default_nettype none

module gba_fe_tb;

	localparam int PIX_DIV        = 2;
	localparam int ROM_BASE_WORD  = 196608;
	localparam int TIMEOUT_CYCLES = 1000000;   // two frames of 210672 cycles, loads and margin

	logic                  clk_sys;
	logic                  reset;
	gba_fe_pkg::ioctl_t    ioctl;
	logic                  pixel_we;
	logic [15:0]           pixel_addr;
	gba_fe_pkg::rgb_t      pixel_data;
	gba_fe_pkg::mem_wr_t   rom_wr;
	gba_fe_pkg::mem_wr_t   bios_wr;
	gba_fe_pkg::quirk_t    quirks;
	logic [26:0]           last_addr;
	gba_fe_pkg::vid_sync_t sync;
	gba_fe_pkg::rgb_t      rgb;

	int                  errors;
	int                  checks;
	int                  cycle_count;
	logic [31:0]         lfsr;
	logic [7:0]          img [512];             // bytes of the next download
	gba_fe_pkg::rgb_t    fb_ref [38400];        // framebuffer contents as written
	gba_fe_pkg::mem_wr_t rom_seen [$];
	gba_fe_pkg::mem_wr_t bios_seen [$];

	gba_fe_top #(
		.PIX_DIV       (PIX_DIV),
		.ROM_BASE_WORD (ROM_BASE_WORD)
	) DUT (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.ioctl      (ioctl),
		.pixel_we   (pixel_we),
		.pixel_addr (pixel_addr),
		.pixel_data (pixel_data),
		.rom_wr     (rom_wr),
		.bios_wr    (bios_wr),
		.quirks     (quirks),
		.last_addr  (last_addr),
		.sync       (sync),
		.rgb        (rgb)
	);

	initial begin
		clk_sys = 1'b0;
		forever #4 clk_sys = ~clk_sys;
	end

	// write pulses are collected mid cycle, away from the edges
	always @(negedge clk_sys) begin
		if (rom_wr.valid)
			rom_seen.push_back(rom_wr);
		if (bios_wr.valid)
			bios_seen.push_back(bios_wr);
	end

	// ========================================
	// helpers

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};   // x^32 + x^22 + x^2 + x + 1
	endfunction

	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			v    = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	task automatic next_cycle;
		@(posedge clk_sys);
		#1;
	endtask

	task automatic expect_eq(input string name, input logic [63:0] exp, input logic [63:0] act);
		checks++;
		assert (act === exp) else begin
			errors++;
			$display("Error %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	`include "gba_fe_tests.svh"

	// ========================================
	// test sequence

	initial begin
		errors     = 0;
		checks     = 0;
		lfsr       = 32'hcb2bc8f5;
		reset      = 1'b1;
		ioctl      = '0;
		pixel_we   = 1'b0;
		pixel_addr = '0;
		pixel_data = '0;
		repeat (2) @(posedge clk_sys);
		#1;
		reset = 1'b0;

		test_reset_state();
		test_rom_load();
		test_bios_load();
		test_header_lookup();
		test_frame_readback();

		$display("checks %0d, value errors %0d, assertion failures %0d",
			checks, errors, DUT.u_checker.fail_count);
		if (errors == 0 && DUT.u_checker.fail_count == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

	initial begin
		cycle_count = 0;
		while (cycle_count < TIMEOUT_CYCLES) begin
			@(posedge clk_sys);
			cycle_count++;
		end
		$display("timeout: the tests did not finish within %0d cycles", cycle_count);
		$display("Test failures found");
		$finish;
	end

endmodule

`default_nettype wire

/* build.f */
+incdir+tb
common/gba_fe_pkg.sv
loader/load_fsm.sv
loader/word_packer.sv
loader/header_scan.sv
video/video_timing.sv
video/frame_buffer.sv
logic/gba_fe_top.sv
tb/gba_fe_checker.sv
tb/gba_fe_tb.sv

/* run_sim.sh */
#!/bin/sh
# compile the front end testbench with Verilator, run it and search the log for the pass message

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
	--top-module gba_fe_tb -f build.f -o gba_fe_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/gba_fe_sim +verilator+error+limit+1000 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q 'All tests passed!' "$LOG"; then
	echo "simulation passed"
	exit 0
else
	echo "simulation failed"
	exit 1
fi
